// File: build.f
rtl/frontend_pkg.sv
rtl/fetch_unit.sv
rtl/instruction_queue.sv
rtl/rv32i_decode.sv
rtl/frontend_top.sv
verif/imem_responder.sv
verif/frontend_tb.sv

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic        clk,
  input  logic        rst,

  // back-pressure from the instruction queue
  input  logic        instr_full,

  // read request towards the instruction memory
  output logic        imem_read,
  output logic [31:0] imem_addr,

  // the same request as seen by the queue, which reserves a slot for it
  output logic [31:0] fetch_pc,
  output logic [63:0] fetch_order
);

  import frontend_pkg::*;

  logic        started;
  logic [31:0] pc;
  logic [63:0] order;

  // started goes high at the first edge where rst is seen low
  // so no read leaves the unit while reset is held
  always_ff @(posedge clk) begin
    if (rst) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  // one read per cycle as long as the queue has a free slot
  assign imem_read = started & ~instr_full;

  assign imem_addr   = pc;
  assign fetch_pc    = pc;
  assign fetch_order = order;

  // pc and order step together, once per issued read
  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= reset_pc;
      order <= 64'd0;
    end else if (imem_read) begin
      pc    <= pc + 32'd4;
      order <= order + 64'd1;
    end
  end

  // the queue cannot reserve a slot while it is full
  // so a read in that state would be lost
  assert_no_read_when_full : assert property (
    @(posedge clk) disable iff (rst)
    instr_full |-> !imem_read
  ) else $error("fetch_unit: read issued while the instruction queue is full");

endmodule : fetch_unit

// File: rtl/frontend_pkg.sv
package frontend_pkg;

  // address of the first instruction fetched after reset
  localparam logic [31:0] reset_pc = 32'h1eceb000;

  // the instruction queue holds 2**iq_depth_bits slots
  localparam int iq_depth_bits = 4;
  localparam int iq_entries = 2 ** iq_depth_bits;

  // RV32I major opcodes, bits [6:0] of the instruction word
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;

  // immediate formats
  // fmt_none covers the R format and every opcode without an immediate
  localparam logic [2:0] fmt_none = 3'd0;
  localparam logic [2:0] fmt_i    = 3'd1;
  localparam logic [2:0] fmt_s    = 3'd2;
  localparam logic [2:0] fmt_b    = 3'd3;
  localparam logic [2:0] fmt_u    = 3'd4;
  localparam logic [2:0] fmt_j    = 3'd5;

  // maps a major opcode onto the format of its immediate
  function automatic logic [2:0] imm_format(input logic [6:0] opcode);
    logic [2:0] fmt;
    case (opcode)
      op_imm, op_load, op_jalr: fmt = fmt_i;
      op_store:                 fmt = fmt_s;
      op_branch:                fmt = fmt_b;
      op_lui, op_auipc:         fmt = fmt_u;
      op_jal:                   fmt = fmt_j;
      default:                  fmt = fmt_none;
    endcase
    return fmt;
  endfunction

endpackage : frontend_pkg

// File: rtl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
  input  logic        clk,
  input  logic        rst,

  // instruction memory port, answers return in request order
  output logic        imem_read,
  output logic [31:0] imem_addr,
  input  logic        imem_resp,
  input  logic [31:0] imem_rdata,

  // issue port towards the consumer
  input  logic        issue_pop,
  output logic        issue_ready,
  output logic [31:0] issue_pc,
  output logic [31:0] issue_pc_next,
  output logic [63:0] issue_order,
  output logic [31:0] issue_instr,
  output logic [6:0]  issue_opcode,
  output logic [2:0]  issue_funct3,
  output logic [6:0]  issue_funct7,
  output logic [4:0]  issue_rs1_s,
  output logic [4:0]  issue_rs2_s,
  output logic [4:0]  issue_rd_s,
  output logic [31:0] issue_imm
);

  logic        instr_full;
  logic [31:0] fetch_pc;
  logic [63:0] fetch_order;

  fetch_unit i_fetch (
    .clk        (clk),
    .rst        (rst),
    .instr_full (instr_full),
    .imem_read  (imem_read),
    .imem_addr  (imem_addr),
    .fetch_pc   (fetch_pc),
    .fetch_order(fetch_order)
  );

  // each memory read reserves one queue slot in the same cycle
  instruction_queue i_queue (
    .clk          (clk),
    .rst          (rst),
    .move_fetch   (imem_read),
    .fetch_pc     (fetch_pc),
    .fetch_order  (fetch_order),
    .imem_resp    (imem_resp),
    .imem_rdata   (imem_rdata),
    .issue_pop    (issue_pop),
    .instr_full   (instr_full),
    .issue_ready  (issue_ready),
    .issue_instr  (issue_instr),
    .issue_pc     (issue_pc),
    .issue_pc_next(issue_pc_next),
    .issue_order  (issue_order)
  );

  rv32i_decode i_decode (
    .inst  (issue_instr),
    .opcode(issue_opcode),
    .funct3(issue_funct3),
    .funct7(issue_funct7),
    .rs1_s (issue_rs1_s),
    .rs2_s (issue_rs2_s),
    .rd_s  (issue_rd_s),
    .imm   (issue_imm)
  );

endmodule : frontend_top

// File: rtl/instruction_queue.sv
`timescale 1ns/1ps

module instruction_queue #(
  parameter int depth_bits = frontend_pkg::iq_depth_bits
) (
  input  logic        clk,
  input  logic        rst,

  // slot reservation at request time
  input  logic        move_fetch,
  input  logic [31:0] fetch_pc,
  input  logic [63:0] fetch_order,

  // in-order answers from the instruction memory
  input  logic        imem_resp,
  input  logic [31:0] imem_rdata,

  // consumer side
  input  logic        issue_pop,
  output logic        instr_full,
  output logic        issue_ready,
  output logic [31:0] issue_instr,
  output logic [31:0] issue_pc,
  output logic [31:0] issue_pc_next,
  output logic [63:0] issue_order
);

  import frontend_pkg::*;

  localparam int entries = 2 ** depth_bits;

  // payload per slot
  logic [31:0] instr_mem [0:entries-1];
  logic [31:0] pc_mem    [0:entries-1];
  logic [63:0] order_mem [0:entries-1];

  // a slot is valid once reserved and ready once its answer has arrived
  logic        valid_arr [0:entries-1];
  logic        ready_arr [0:entries-1];

  // alloc_ptr is the next slot to reserve, fill_ptr the next slot to be answered
  // tail_ptr points at the oldest slot, which is the one that issues
  logic [depth_bits-1:0] alloc_ptr;
  logic [depth_bits-1:0] fill_ptr;
  logic [depth_bits-1:0] tail_ptr;

  // when the reserve pointer has wrapped onto a slot still in use there is no room
  assign instr_full  = valid_arr[alloc_ptr];
  assign issue_ready = ready_arr[tail_ptr];

  assign issue_instr   = instr_mem[tail_ptr];
  assign issue_pc      = pc_mem[tail_ptr];
  assign issue_pc_next = pc_mem[tail_ptr] + 32'd4;
  assign issue_order   = order_mem[tail_ptr];

  // pointers and slot status
  // push, answer and pop always land on different slots in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_ptr <= '0;
      fill_ptr  <= '0;
      tail_ptr  <= '0;
      for (int i = 0; i < entries; i++) begin
        valid_arr[i] <= 1'b0;
        ready_arr[i] <= 1'b0;
      end
    end else begin
      if (move_fetch) begin
        valid_arr[alloc_ptr] <= 1'b1;
        alloc_ptr            <= alloc_ptr + 1'b1;
      end
      if (imem_resp) begin
        ready_arr[fill_ptr] <= 1'b1;
        fill_ptr            <= fill_ptr + 1'b1;
      end
      if (issue_pop) begin
        valid_arr[tail_ptr] <= 1'b0;
        ready_arr[tail_ptr] <= 1'b0;
        tail_ptr            <= tail_ptr + 1'b1;
      end
    end
  end

  // pc and order are known at request time, the word only on the answer
  always_ff @(posedge clk) begin
    if (move_fetch) begin
      pc_mem[alloc_ptr]    <= fetch_pc;
      order_mem[alloc_ptr] <= fetch_order;
    end
    if (imem_resp) begin
      instr_mem[fill_ptr] <= imem_rdata;
    end
  end

  assert_no_push_when_full : assert property (
    @(posedge clk) disable iff (rst)
    move_fetch |-> !instr_full
  ) else $error("instruction_queue: push while full");

  assert_pop_needs_ready : assert property (
    @(posedge clk) disable iff (rst)
    issue_pop |-> issue_ready
  ) else $error("instruction_queue: pop of a slot that has no instruction yet");

  // an answer must belong to a request that has reserved a slot and is not yet served
  assert_resp_has_slot : assert property (
    @(posedge clk) disable iff (rst)
    imem_resp |-> (valid_arr[fill_ptr] && !ready_arr[fill_ptr])
  ) else $error("instruction_queue: memory answer without an outstanding request");

endmodule : instruction_queue

// File: rtl/rv32i_decode.sv
`timescale 1ns/1ps

module rv32i_decode (
  input  logic [31:0] inst,

  output logic [6:0]  opcode,
  output logic [2:0]  funct3,
  output logic [6:0]  funct7,
  output logic [4:0]  rs1_s,
  output logic [4:0]  rs2_s,
  output logic [4:0]  rd_s,
  output logic [31:0] imm
);

  import frontend_pkg::*;

  logic [2:0]  fmt;
  logic        sign;

  // immediates of every format, built side by side from the raw word
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  // fixed fields sit at the same bit positions in all formats
  assign opcode = inst[6:0];
  assign rd_s   = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1_s  = inst[19:15];
  assign rs2_s  = inst[24:20];
  assign funct7 = inst[31:25];

  // bit 31 is the sign of every RV32I immediate
  assign sign = inst[31];

  assign imm_i = {{20{sign}}, inst[31:20]};
  assign imm_s = {{20{sign}}, inst[31:25], inst[11:7]};

  // branch offsets are in half words, so bit 0 is always zero
  assign imm_b = {{19{sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  // upper immediate fills bits 31 to 12, the low part is zero
  assign imm_u = {inst[31:12], 12'd0};

  assign imm_j = {{11{sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign fmt = imm_format(inst[6:0]);

  always_comb begin
    case (fmt)
      fmt_i:   imm = imm_i;
      fmt_s:   imm = imm_s;
      fmt_b:   imm = imm_b;
      fmt_u:   imm = imm_u;
      fmt_j:   imm = imm_j;
      // register ops and unknown opcodes carry no immediate
      default: imm = 32'd0;
    endcase
  end

endmodule : rv32i_decode

// File: run_sim.sh
#!/bin/sh
# builds the instruction front end testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module frontend_tb -f build.f -o frontend_sim \
  && ./obj_dir/frontend_sim | tee /dev/stderr | grep -qF "*** PASSED ***" \
  && echo "simulation finished without errors" \
  || { echo "simulation reported a failure"; exit 1; }

exit 0

// File: verif/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

  import frontend_pkg::*;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 16;
  localparam int rows         = 24;
  localparam int num_pops     = 48;
  localparam int stall_at     = 16;
  localparam int stall_cycles = 60;

  logic        clk;
  logic        rst;
  logic        imem_read;
  logic [31:0] imem_addr;
  logic        imem_resp;
  logic [31:0] imem_rdata;
  logic        issue_pop;
  logic        issue_ready;
  logic [31:0] issue_pc;
  logic [31:0] issue_pc_next;
  logic [63:0] issue_order;
  logic [31:0] issue_instr;
  logic [6:0]  issue_opcode;
  logic [2:0]  issue_funct3;
  logic [6:0]  issue_funct7;
  logic [4:0]  issue_rs1_s;
  logic [4:0]  issue_rs2_s;
  logic [4:0]  issue_rd_s;
  logic [31:0] issue_imm;

  // program table, one instruction word and its expected decode per row
  logic [31:0] prog_word  [rows];
  logic [6:0]  exp_opcode [rows];
  logic [2:0]  exp_funct3 [rows];
  logic [6:0]  exp_funct7 [rows];
  logic [4:0]  exp_rs1    [rows];
  logic [4:0]  exp_rs2    [rows];
  logic [4:0]  exp_rd     [rows];
  logic [31:0] exp_imm    [rows];
  int          row_count;

  // strobes counted by the bus monitor
  int reads_seen;
  int pops_seen;

  frontend_top i_dut (
    .clk          (clk),
    .rst          (rst),
    .imem_read    (imem_read),
    .imem_addr    (imem_addr),
    .imem_resp    (imem_resp),
    .imem_rdata   (imem_rdata),
    .issue_pop    (issue_pop),
    .issue_ready  (issue_ready),
    .issue_pc     (issue_pc),
    .issue_pc_next(issue_pc_next),
    .issue_order  (issue_order),
    .issue_instr  (issue_instr),
    .issue_opcode (issue_opcode),
    .issue_funct3 (issue_funct3),
    .issue_funct7 (issue_funct7),
    .issue_rs1_s  (issue_rs1_s),
    .issue_rs2_s  (issue_rs2_s),
    .issue_rd_s   (issue_rd_s),
    .issue_imm    (issue_imm)
  );

  imem_responder #(.rows(rows), .max_delay(5)) i_mem (
    .clk          (clk),
    .rst          (rst),
    .imem_read    (imem_read),
    .imem_addr    (imem_addr),
    .imem_resp    (imem_resp),
    .imem_rdata   (imem_rdata),
    .program_words(prog_word)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      abort_run();
    end
  endtask

  // the word is laid out as funct7 rs2 rs1 funct3 rd opcode, imm is worked out by hand
  task automatic add_row(input logic [6:0] funct7, input logic [4:0] rs2,
                         input logic [4:0] rs1, input logic [2:0] funct3,
                         input logic [4:0] rd, input logic [6:0] opcode,
                         input logic [31:0] imm);
    prog_word[row_count]  = {funct7, rs2, rs1, funct3, rd, opcode};
    exp_opcode[row_count] = opcode;
    exp_funct3[row_count] = funct3;
    exp_funct7[row_count] = funct7;
    exp_rs1[row_count]    = rs1;
    exp_rs2[row_count]    = rs2;
    exp_rd[row_count]     = rd;
    exp_imm[row_count]    = imm;
    row_count++;
  endtask

  task automatic load_program();
    row_count = 0;
    add_row(7'h00, 5'd2,  5'd1,  3'd0, 5'd3,  op_reg,    32'h0000_0000);
    add_row(7'h20, 5'd5,  5'd4,  3'd0, 5'd6,  op_reg,    32'h0000_0000);
    add_row(7'h20, 5'd31, 5'd30, 3'd5, 5'd29, op_reg,    32'h0000_0000);
    add_row(7'h00, 5'd1,  5'd0,  3'd0, 5'd1,  op_imm,    32'h0000_0001);
    add_row(7'h7f, 5'd31, 5'd2,  3'd0, 5'd2,  op_imm,    32'hffff_ffff);
    add_row(7'h3f, 5'd31, 5'd7,  3'd4, 5'd8,  op_imm,    32'h0000_07ff);
    add_row(7'h40, 5'd0,  5'd9,  3'd6, 5'd10, op_imm,    32'hffff_f800);
    add_row(7'h01, 5'd4,  5'd2,  3'd2, 5'd11, op_load,   32'h0000_0024);
    add_row(7'h7e, 5'd16, 5'd3,  3'd0, 5'd12, op_load,   32'hffff_ffd0);
    add_row(7'h00, 5'd8,  5'd1,  3'd0, 5'd0,  op_jalr,   32'h0000_0008);
    add_row(7'h7f, 5'd28, 5'd5,  3'd0, 5'd1,  op_jalr,   32'hffff_fffc);
    add_row(7'h00, 5'd6,  5'd2,  3'd2, 5'd8,  op_store,  32'h0000_0008);
    add_row(7'h7f, 5'd7,  5'd3,  3'd0, 5'd31, op_store,  32'hffff_ffff);
    add_row(7'h2a, 5'd9,  5'd10, 3'd1, 5'd21, op_store,  32'h0000_0555);
    add_row(7'h00, 5'd2,  5'd1,  3'd0, 5'd8,  op_branch, 32'h0000_0008);
    add_row(7'h7f, 5'd4,  5'd5,  3'd1, 5'd31, op_branch, 32'hffff_fffe);
    add_row(7'h40, 5'd6,  5'd7,  3'd4, 5'd1,  op_branch, 32'hffff_f800);
    add_row(7'h3f, 5'd8,  5'd9,  3'd5, 5'd30, op_branch, 32'h0000_07fe);
    add_row(7'h12, 5'd19, 5'd20, 3'd5, 5'd3,  op_lui,    32'h253a_5000);
    add_row(7'h7f, 5'd31, 5'd31, 3'd7, 5'd5,  op_auipc,  32'hffff_f000);
    add_row(7'h00, 5'd16, 5'd0,  3'd0, 5'd1,  op_jal,    32'h0000_0010);
    add_row(7'h7f, 5'd31, 5'd31, 3'd7, 5'd0,  op_jal,    32'hffff_fffe);
    add_row(7'h00, 5'd1,  5'd21, 3'd3, 5'd2,  op_jal,    32'h000a_b800);
    // system opcode, which has no immediate format here
    add_row(7'h55, 5'd10, 5'd11, 3'd1, 5'd12, 7'h73,     32'h0000_0000);
  endtask

  // waits for a filled tail slot, checks it mid-cycle, then pops it for one cycle
  task automatic pop_one(input int idx);
    int row;
    row = idx % rows;
    @(negedge clk);
    while (!issue_ready) @(negedge clk);
    check_value("issue_pc", issue_pc, reset_pc + 32'(4 * idx));
    check_value("issue_pc_next", issue_pc_next, reset_pc + 32'(4 * idx + 4));
    check_value("issue_order", issue_order, 64'(idx));
    check_value("issue_instr", issue_instr, prog_word[row]);
    check_value("issue_opcode", issue_opcode, exp_opcode[row]);
    check_value("issue_funct3", issue_funct3, exp_funct3[row]);
    check_value("issue_funct7", issue_funct7, exp_funct7[row]);
    check_value("issue_rs1_s", issue_rs1_s, exp_rs1[row]);
    check_value("issue_rs2_s", issue_rs2_s, exp_rs2[row]);
    check_value("issue_rd_s", issue_rd_s, exp_rd[row]);
    check_value("issue_imm", issue_imm, exp_imm[row]);
    @(posedge clk);
    #1;
    issue_pop = 1'b1;
    @(posedge clk);
    #1;
    issue_pop = 1'b0;
  endtask

  // with no pops the queue fills up and fetch has to stop
  task automatic hold_pops();
    repeat (stall_cycles) @(posedge clk);
    #1;
    check_value("reads_minus_pops", 64'(reads_seen - pops_seen), 64'(iq_entries));
  endtask

  // bus monitor, samples the strobes mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      if (imem_read !== 1'b0 || issue_ready !== 1'b0) begin
        $display("imem_read or issue_ready was high while reset was held");
        abort_run();
      end
    end else begin
      if (issue_pop && !issue_ready) begin
        $display("issue_pop was driven while issue_ready was low");
        abort_run();
      end
      if (imem_read && reads_seen - pops_seen >= iq_entries) begin
        $display("a read was issued with every queue slot already taken");
        abort_run();
      end
      if (imem_read) begin
        check_value("imem_addr", imem_addr, reset_pc + 32'(4 * reads_seen));
        reads_seen++;
      end
      if (issue_pop) begin
        pops_seen++;
      end
    end
  end

  initial begin
    #(num_pops * 40 * clk_period);
    $display("timeout: the instructions were not all issued in time");
    abort_run();
  end

  initial begin
    int gap;
    void'($urandom(4285));
    clk        = 1'b0;
    rst        = 1'b1;
    issue_pop  = 1'b0;
    reads_seen = 0;
    pops_seen  = 0;
    load_program();
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < num_pops; i++) begin
      if (i == stall_at) begin
        hold_pops();
      end
      gap = $urandom_range(3, 0);
      repeat (gap) @(posedge clk);
      pop_one(i);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule : frontend_tb

// File: verif/imem_responder.sv
`timescale 1ns/1ps

module imem_responder #(
  parameter int rows      = 24,
  parameter int max_delay = 5
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        imem_read,
  input  logic [31:0] imem_addr,
  output logic        imem_resp,
  output logic [31:0] imem_rdata,
  input  logic [31:0] program_words [rows]
);

  import frontend_pkg::*;

  logic [31:0] pending [$];
  logic [31:0] head;
  logic        in_reset;
  int unsigned hold;
  int unsigned row;

  // reads are answered strictly in order, the head waits hold cycles before its answer
  initial begin
    imem_resp  = 1'b0;
    imem_rdata = 32'd0;
    in_reset   = 1'b1;
    hold       = 0;
    forever begin
      // requests and reset are taken mid-cycle where they are stable
      @(negedge clk);
      in_reset = rst;
      if (rst) begin
        pending.delete();
        hold = 0;
      end else if (imem_read) begin
        pending.push_back(imem_addr);
      end
      @(posedge clk);
      #1;
      imem_resp = 1'b0;
      if (!in_reset && pending.size() > 0) begin
        if (hold == 0) begin
          head       = pending.pop_front();
          row        = ((head - reset_pc) >> 2) % rows;
          imem_rdata = program_words[row];
          imem_resp  = 1'b1;
          hold       = $urandom_range(max_delay, 0);
        end else begin
          hold--;
        end
      end
    end
  end

endmodule : imem_responder
